//--- files.f
+incdir+source
source/cw_pkg.sv
source/wt_req_intake.sv
source/aw_burst_splitter.sv
source/burst_table.sv
source/wdata_packer.sv
source/wdata_fifo.sv
source/conv_out_wchn.sv
test/tb_conv_out_wchn.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, search the log for the fail message

cd "$(dirname "$0")" || exit 1

top=tb_conv_out_wchn
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$top" -f files.f --Mdir obj_dir -o "$top"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' "$log"; then
	exit 1
fi
if ! grep -qF '*** PASSED ***' "$log"; then
	echo "no result line found in $log"
	exit 1
fi
exit 0

//--- test/tb_conv_out_wchn.sv
`timescale 1ns/1ps
`include "cw_defs.svh"

module tb_conv_out_wchn import cw_pkg::*;
();

	localparam int N_REQ = 24;
	localparam int TIMEOUT_CYCLES = 200000;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	addr_t wt_req_addr_i = '0;
	btt_t wt_req_btt_i = '0;
	logic wt_req_valid_i = 1'b0;
	logic wt_req_ready_o;
	logic wt_req_fns_o;
	feat_t res_data_i = '0;
	logic res_last_i = 1'b0;
	logic res_valid_i = 1'b0;
	logic res_ready_o;
	addr_t awaddr_o;
	burst_len_t awlen_o;
	logic awvalid_o;
	logic awready_i = 1'b0;
	wdata_t wdata_o;
	wstrb_t wstrb_o;
	logic wlast_o;
	logic wvalid_o;
	logic wready_i = 1'b0;
	logic bvalid_i = 1'b0;

	logic [31:0] lfsr = 32'h9702_d4b3;
	logic [31:0] stall_bits;
	logic stall_on = 1'b0; // back-pressure phase
	addr_t req_addr_mem [N_REQ];
	btt_t req_btt_mem [N_REQ];
	feat_t feat_mem [$]; // whole feature stream, all requests
	logic last_mem [$];

	// expected AXI traffic in issue order
	addr_t exp_awaddr_q [$];
	burst_len_t exp_awlen_q [$];
	logic exp_blast_q [$]; // burst closes its request
	wdata_t exp_wdata_q [$];
	wstrb_t exp_wstrb_q [$];
	logic exp_wlast_q [$];
	addr_t exp_addr;
	burst_len_t exp_len;
	logic exp_blast;
	wdata_t exp_data;
	wstrb_t exp_strb;
	logic exp_last;

	int req_idx = 0;
	int feat_idx = 0;
	int feat_req = 0; // request owning the next feature
	int aw_seen = 0; // AW handshakes
	int wb_seen = 0; // complete W bursts
	int b_sent = 0;
	int fns_cnt = 0;
	int beats_checked = 0;
	int mismatch_cnt = 0;
	int fault_cnt = 0;

	conv_out_wchn u_conv_out_wchn (
		.clk, .rst_n,
		.wt_req_addr_i, .wt_req_btt_i, .wt_req_valid_i, .wt_req_ready_o, .wt_req_fns_o,
		.res_data_i, .res_last_i, .res_valid_i, .res_ready_o,
		.awaddr_o, .awlen_o, .awvalid_o, .awready_i,
		.wdata_o, .wstrb_o, .wlast_o, .wvalid_o, .wready_i,
		.bvalid_i
	);

	always #20 clk = ~clk;

	// galois lfsr, one step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic wdata_t byte_mask(input wstrb_t s);
		wdata_t m;
		for (int i = 0; i < 8; i++)
			m[i*8 +: 8] = {8{s[i]}};
		return m;
	endfunction

	// one request -> expected bursts and beats, features at feat_mem[f0..]
	function automatic void expand_request(input addr_t addr, input btt_t btt, input int f0);
		addr_t baddr;
		int off;
		int left;
		int len;
		int beat;
		int byte_pos;
		wdata_t data;
		wstrb_t strb;
		off = int'(addr[2:0]);
		left = (int'(btt) + off + 7) / 8;
		baddr = {addr[`CW_ADDR_W-1:3], 3'b000}; // bursts start beat aligned
		beat = 0;
		while (left > 0)
		begin
			len = (4096 - int'(baddr[11:0])) / 8; // beats to the page edge
			if (len > `CW_MAX_BURST)
				len = `CW_MAX_BURST;
			if (len > left)
				len = left;
			exp_awaddr_q.push_back(baddr);
			exp_awlen_q.push_back(burst_len_t'(len - 1));
			exp_blast_q.push_back(left == len);
			for (int j = 0; j < len; j++)
			begin
				data = '0;
				strb = '0;
				for (int i = 0; i < `CW_FEATS_PER_BEAT; i++)
				begin
					byte_pos = (beat + j) * 8 + i * 2; // lane i, little endian
					if (byte_pos >= off && byte_pos < off + int'(btt))
					begin
						data[i*`CW_FEAT_W +: `CW_FEAT_W] = feat_mem[f0 + (byte_pos - off) / 2];
						strb[i*2 +: 2] = 2'b11;
					end
				end
				exp_wdata_q.push_back(data);
				exp_wstrb_q.push_back(strb);
				exp_wlast_q.push_back(j == len - 1);
			end
			baddr = baddr + addr_t'(len * 8);
			left = left - len;
			beat = beat + len;
		end
	endfunction

	task automatic flag_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] want);
		mismatch_cnt++;
		$display("ERR %s got %h exp %h at %0t", sig, got, want, $time);
	endtask

	task automatic report_fault(input string what);
		fault_cnt++;
		$display("%s at %0t", what, $time);
	endtask

	// requests, features and stalls, all on the rising edge
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (wt_req_valid_i && wt_req_ready_o)
				req_idx++;
			stall_on = (req_idx >= N_REQ / 2); // second half with back-pressure
			if (req_idx < N_REQ)
			begin
				wt_req_valid_i <= 1'b1;
				wt_req_addr_i <= req_addr_mem[req_idx];
				wt_req_btt_i <= req_btt_mem[req_idx];
			end
			else
				wt_req_valid_i <= 1'b0;
			if (res_valid_i && res_ready_o)
			begin
				// a feature only goes in once its request is taken
				assert (feat_req < req_idx)
				else
					report_fault("res_ready_o took a feature before its request was accepted");
				if (res_last_i)
					feat_req++;
				feat_idx++;
			end
			stall_bits = take_bits(5);
			if (!res_valid_i || res_ready_o) // never drop an offered feature
			begin
				if (feat_idx < feat_mem.size() && (!stall_on || stall_bits[1:0] != 2'd0))
				begin
					res_valid_i <= 1'b1;
					res_data_i <= feat_mem[feat_idx];
					res_last_i <= last_mem[feat_idx];
				end
				else
					res_valid_i <= 1'b0;
			end
			awready_i <= !stall_on || stall_bits[2];
			wready_i <= !stall_on || stall_bits[4:3] != 2'd0;
		end
	end

	// slave model, compares AW, W and B against the reference
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (awvalid_o && awready_i)
			begin
				assert (exp_awlen_q.size() > 0)
				else
					report_fault("AW burst issued with none expected");
				if (exp_awlen_q.size() > 0)
				begin
					exp_addr = exp_awaddr_q.pop_front();
					exp_len = exp_awlen_q.pop_front();
					assert (awaddr_o == exp_addr)
					else
						flag_mismatch("awaddr_o", awaddr_o, exp_addr);
					assert (awlen_o == exp_len)
					else
						flag_mismatch("awlen_o", awlen_o, exp_len);
				end
				assert (int'(awaddr_o[11:0]) + (int'(awlen_o) + 1) * 8 <= 4096)
				else
					report_fault($sformatf("burst at %h crosses a 4 KB boundary", awaddr_o));
				aw_seen++;
			end
			if (wvalid_o && wready_i)
			begin
				assert (exp_wstrb_q.size() > 0)
				else
					report_fault("W beat issued with none expected");
				if (exp_wstrb_q.size() > 0)
				begin
					exp_data = exp_wdata_q.pop_front();
					exp_strb = exp_wstrb_q.pop_front();
					exp_last = exp_wlast_q.pop_front();
					assert (wstrb_o == exp_strb)
					else
						flag_mismatch("wstrb_o", wstrb_o, exp_strb);
					// only strobed bytes carry data
					assert ((wdata_o & byte_mask(exp_strb)) == (exp_data & byte_mask(exp_strb)))
					else
						flag_mismatch("wdata_o", wdata_o, exp_data);
					assert (wlast_o == exp_last)
					else
						flag_mismatch("wlast_o", wlast_o, exp_last);
					if (exp_last)
						wb_seen++;
					beats_checked++;
				end
			end
			if (bvalid_i)
			begin
				exp_blast = exp_blast_q.pop_front();
				assert (wt_req_fns_o == exp_blast)
				else
					flag_mismatch("wt_req_fns_o", wt_req_fns_o, exp_blast);
			end
			else
			begin
				assert (!wt_req_fns_o)
				else
					report_fault("wt_req_fns_o pulsed without a B response");
			end
			if (wt_req_fns_o)
				fns_cnt++;
			// B once a burst has its address and its last beat
			if (b_sent < aw_seen && b_sent < wb_seen)
			begin
				bvalid_i <= 1'b1;
				b_sent++;
			end
			else
				bvalid_i <= 1'b0;
		end
	end

	initial
	begin
		addr_t a;
		logic [31:0] rnd;
		int n_bytes;
		int f0;
		int wait_cycles;
		for (int r = 0; r < N_REQ; r++)
		begin
			rnd = take_bits(32);
			a = {rnd[31:3], 3'b000};
			rnd = take_bits(2);
			if (rnd[1:0] == 2'd0)
				a[11:3] = 9'h1ff - 9'(take_bits(5)); // within one burst of a 4 KB edge
			a[2:1] = 2'(take_bits(2)); // start lane
			rnd = take_bits(2);
			case (rnd[1:0])
				2'd0: n_bytes = 2 * (1 + int'(take_bits(4)));
				2'd3: n_bytes = 2 * (1 + int'(take_bits(10)));
				default: n_bytes = 2 * (1 + int'(take_bits(7)));
			endcase
			if (n_bytes + int'(a[2:0]) > 2048)
				n_bytes = 2048 - int'(a[2:0]); // 256 beats at most
			f0 = feat_mem.size();
			for (int k = 0; k < n_bytes / 2; k++)
			begin
				feat_mem.push_back(feat_t'(take_bits(`CW_FEAT_W)));
				last_mem.push_back(k == n_bytes / 2 - 1);
			end
			req_addr_mem[r] = a;
			req_btt_mem[r] = btt_t'(n_bytes);
			expand_request(a, btt_t'(n_bytes), f0);
		end

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		// first cycle out of reset, inputs still idle
		assert (wt_req_ready_o == 1'b1)
		else
			flag_mismatch("wt_req_ready_o", wt_req_ready_o, 1'b1);
		assert (awvalid_o == 1'b0)
		else
			flag_mismatch("awvalid_o", awvalid_o, 1'b0);
		assert (wvalid_o == 1'b0)
		else
			flag_mismatch("wvalid_o", wvalid_o, 1'b0);
		assert (wt_req_fns_o == 1'b0)
		else
			flag_mismatch("wt_req_fns_o", wt_req_fns_o, 1'b0);

		wait_cycles = 0;
		while (fns_cnt < N_REQ && wait_cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (fns_cnt < N_REQ)
			report_fault($sformatf("timeout, only %0d of %0d requests completed", fns_cnt, N_REQ));
		assert (exp_awlen_q.size() == 0 && exp_wstrb_q.size() == 0)
		else
			report_fault("expected bursts or beats never appeared on the AXI bus");

		$display("checked %0d bursts, %0d beats, %0d requests: %0d mismatches, %0d other errors",
			aw_seen, beats_checked, fns_cnt, mismatch_cnt, fault_cnt);
		if (mismatch_cnt == 0 && fault_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- source/conv_out_wchn.sv
`timescale 1ns/1ps
`include "cw_defs.svh"

module conv_out_wchn import cw_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// write requests
	input  addr_t      wt_req_addr_i,
	input  btt_t       wt_req_btt_i,
	input  logic       wt_req_valid_i,
	output logic       wt_req_ready_o,
	output logic       wt_req_fns_o, // last B of a request
	// feature stream
	input  feat_t      res_data_i,
	input  logic       res_last_i,
	input  logic       res_valid_i,
	output logic       res_ready_o,
	// axi AW
	output addr_t      awaddr_o,
	output burst_len_t awlen_o,
	output logic       awvalid_o,
	input  logic       awready_i,
	// axi W
	output wdata_t     wdata_o,
	output wstrb_t     wstrb_o,
	output logic       wlast_o,
	output logic       wvalid_o,
	input  logic       wready_i,
	// axi B, bready tied high outside
	input  logic       bvalid_i
);

	logic req_start;
	addr_t start_addr;
	beat_cnt_t beat_cnt;
	keep_id_t first_kid;
	keep_id_t last_kid;
	logic msg_valid;
	logic msg_pop;
	logic req_split_done;
	logic commit_valid;
	addr_t commit_addr;
	burst_len_t commit_len;
	logic commit_ok;
	burst_len_t data_len;
	logic data_avail;
	logic data_done;
	logic buf_wen;
	wdata_t buf_data;
	wstrb_t buf_strb;
	logic buf_last;
	logic buf_full_n;

	wt_req_intake u_intake (
		.clk, .rst_n,
		.wt_req_addr_i, .wt_req_btt_i, .wt_req_valid_i, .wt_req_ready_o,
		.req_split_done_i(req_split_done), .msg_pop_i(msg_pop),
		.req_start_o(req_start), .start_addr_o(start_addr), .beat_cnt_o(beat_cnt),
		.first_kid_o(first_kid), .last_kid_o(last_kid), .msg_valid_o(msg_valid)
	);

	aw_burst_splitter u_splitter (
		.clk, .rst_n,
		.req_start_i(req_start), .start_addr_i(start_addr), .beat_cnt_i(beat_cnt),
		.commit_ok_i(commit_ok), .bvalid_i,
		.req_split_done_o(req_split_done), .commit_valid_o(commit_valid),
		.commit_addr_o(commit_addr), .commit_len_o(commit_len), .wt_req_fns_o
	);

	burst_table u_table (
		.clk, .rst_n,
		.commit_valid_i(commit_valid), .commit_addr_i(commit_addr), .commit_len_i(commit_len),
		.data_done_i(data_done), .awready_i,
		.commit_ok_o(commit_ok), .data_len_o(data_len), .data_avail_o(data_avail),
		.awaddr_o, .awlen_o, .awvalid_o
	);

	wdata_packer u_packer (
		.clk, .rst_n,
		.res_data_i, .res_last_i, .res_valid_i, .res_ready_o,
		.first_kid_i(first_kid), .last_kid_i(last_kid), .msg_valid_i(msg_valid),
		.msg_pop_o(msg_pop), .data_len_i(data_len), .data_avail_i(data_avail),
		.data_done_o(data_done), .buf_full_n_i(buf_full_n), .buf_wen_o(buf_wen),
		.buf_data_o(buf_data), .buf_strb_o(buf_strb), .buf_last_o(buf_last)
	);

	// W beats wait here for wready
	wdata_fifo #(
		.DEPTH(`CW_WBUF_DEPTH)
	) u_wbuf (
		.clk, .rst_n,
		.wen_i(buf_wen), .din_data_i(buf_data), .din_strb_i(buf_strb),
		.din_last_i(buf_last), .full_n_o(buf_full_n),
		.ren_i(wready_i), .dout_data_o(wdata_o), .dout_strb_o(wstrb_o),
		.dout_last_o(wlast_o), .empty_n_o(wvalid_o)
	);

endmodule

//--- source/wdata_fifo.sv
`timescale 1ns/1ps
`include "cw_defs.svh"

module wdata_fifo import cw_pkg::*;
#(
	parameter int DEPTH = `CW_WBUF_DEPTH
)
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   wen_i,
	input  wdata_t din_data_i,
	input  wstrb_t din_strb_i,
	input  logic   din_last_i,
	output logic   full_n_o,
	input  logic   ren_i,
	output wdata_t dout_data_o,
	output wstrb_t dout_strb_o,
	output logic   dout_last_o,
	output logic   empty_n_o
);

	localparam int AW = $clog2(DEPTH);

	wdata_t mem_data [DEPTH];
	wstrb_t mem_strb [DEPTH];
	logic mem_last [DEPTH];
	logic [AW-1:0] wptr; // wraps, depth is a power of two
	logic [AW-1:0] rptr;
	logic [AW:0] cnt;
	logic wr;
	logic rd;

	assign full_n_o = (cnt != (AW+1)'(DEPTH));
	assign empty_n_o = (cnt != '0);
	assign wr = wen_i & full_n_o;
	assign rd = ren_i & empty_n_o;

	// head word always on the outputs
	assign dout_data_o = mem_data[rptr];
	assign dout_strb_o = mem_strb[rptr];
	assign dout_last_o = mem_last[rptr];

	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			mem_data[wptr] <= din_data_i;
			mem_strb[wptr] <= din_strb_i;
			mem_last[wptr] <= din_last_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wptr <= '0;
			rptr <= '0;
			cnt <= '0;
		end
		else
		begin
			if (wr)
				wptr <= wptr + 1'b1;
			if (rd)
				rptr <= rptr + 1'b1;
			cnt <= cnt + {{AW{1'b0}}, wr} - {{AW{1'b0}}, rd};
		end
	end

endmodule

//--- source/wdata_packer.sv
`timescale 1ns/1ps
`include "cw_defs.svh"

module wdata_packer import cw_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  feat_t      res_data_i,
	input  logic       res_last_i,
	input  logic       res_valid_i,
	output logic       res_ready_o,
	input  keep_id_t   first_kid_i,
	input  keep_id_t   last_kid_i,
	input  logic       msg_valid_i,
	output logic       msg_pop_o,
	input  burst_len_t data_len_i,
	input  logic       data_avail_i,
	output logic       data_done_o,
	input  logic       buf_full_n_i,
	output logic       buf_wen_o,
	output wdata_t     buf_data_o,
	output wstrb_t     buf_strb_o,
	output logic       buf_last_o
);

	localparam int NL = `CW_FEATS_PER_BEAT;
	localparam int FW = `CW_FEAT_W;
	localparam wstrb_t STRB_ALL = '1;

	logic [NL-1:0] lane_first; // lane of a request's first feature
	logic [NL-1:0] lane_cur; // one-hot write lane
	logic [NL-1:0] lane_reg;
	logic first_feat;
	logic first_beat;
	logic close_beat;
	logic accept;
	logic beat_fire;
	logic last_beat;
	logic ready_s0;
	feat_t feat_set [NL];
	wdata_t beat_data;
	wstrb_t first_keep;
	wstrb_t last_keep;
	wstrb_t strb_s0;
	burst_len_t beat_id; // beat index inside the burst
	logic valid_s1;
	wdata_t data_s1;
	wstrb_t strb_s1;
	logic last_s1;

	assign lane_first = {{(NL-1){1'b0}}, 1'b1} << first_kid_i[2:1];
	assign lane_cur = first_feat ? lane_first : lane_reg;
	assign close_beat = lane_cur[NL-1] | res_last_i;

	assign ready_s0 = ~valid_s1 | buf_full_n_i;
	// only the closing feature needs the output stage
	assign res_ready_o = msg_valid_i & data_avail_i & (~close_beat | ready_s0);
	assign accept = res_valid_i & res_ready_o;
	assign beat_fire = accept & close_beat;
	assign last_beat = (beat_id == data_len_i);
	assign data_done_o = beat_fire & last_beat;
	assign msg_pop_o = accept & res_last_i;

	// incoming feature goes straight into its lane
	always_comb
	begin
		for (int i = 0; i < NL; i++)
			beat_data[i*FW +: FW] = lane_cur[i] ? res_data_i : feat_set[i];
	end

	assign first_keep = STRB_ALL << first_kid_i; // bytes from first_kid up
	assign last_keep = STRB_ALL >> (3'd7 - last_kid_i); // bytes up to last_kid
	assign strb_s0 = (first_beat ? first_keep : STRB_ALL) & (res_last_i ? last_keep : STRB_ALL);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			first_feat <= 1'b1;
			lane_reg <= '0;
		end
		else if (accept)
		begin
			first_feat <= res_last_i;
			lane_reg <= {lane_cur[NL-2:0], lane_cur[NL-1]}; // rotate
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NL; i++)
			if (accept & lane_cur[i])
				feat_set[i] <= res_data_i;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			first_beat <= 1'b1;
			beat_id <= '0;
		end
		else if (beat_fire)
		begin
			first_beat <= res_last_i;
			beat_id <= last_beat ? '0 : beat_id + 1'b1;
		end
	end

	// output stage, holds while the buffer is full
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			valid_s1 <= 1'b0;
		else if (ready_s0)
			valid_s1 <= beat_fire;
	end

	always_ff @(posedge clk)
	begin
		if (beat_fire)
		begin
			data_s1 <= beat_data;
			strb_s1 <= strb_s0;
			last_s1 <= last_beat;
		end
	end

	assign buf_wen_o = valid_s1 & buf_full_n_i;
	assign buf_data_o = data_s1;
	assign buf_strb_o = strb_s1;
	assign buf_last_o = last_s1;

endmodule

//--- source/burst_table.sv
`timescale 1ns/1ps
`include "cw_defs.svh"

module burst_table import cw_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       commit_valid_i,
	input  addr_t      commit_addr_i,
	input  burst_len_t commit_len_i,
	input  logic       data_done_i, // last beat of the oldest launched burst
	input  logic       awready_i,
	output logic       commit_ok_o,
	output burst_len_t data_len_o,
	output logic       data_avail_o,
	output addr_t      awaddr_o,
	output burst_len_t awlen_o,
	output logic       awvalid_o
);

	localparam logic [1:0] ST_FREE = 2'b00;
	localparam logic [1:0] ST_LAUNCHED = 2'b01; // address known, data pending
	localparam logic [1:0] ST_READY = 2'b11; // data buffered, AW may go

	addr_t tbl_addr [`CW_OUTSTANDING];
	burst_len_t tbl_len [`CW_OUTSTANDING];
	logic [1:0] tbl_flag [`CW_OUTSTANDING];
	tbl_ptr_t cmt_ptr;
	tbl_ptr_t prep_ptr;
	tbl_ptr_t disp_ptr;
	logic commit;
	logic prepared;
	logic dispatched;

	assign commit_ok_o = (tbl_flag[cmt_ptr] == ST_FREE);
	assign data_avail_o = (tbl_flag[prep_ptr] == ST_LAUNCHED);
	assign data_len_o = tbl_len[prep_ptr];
	assign awvalid_o = (tbl_flag[disp_ptr] == ST_READY);
	assign awaddr_o = tbl_addr[disp_ptr];
	assign awlen_o = tbl_len[disp_ptr];

	assign commit = commit_valid_i & commit_ok_o;
	assign prepared = data_done_i & data_avail_o;
	assign dispatched = awready_i & awvalid_o;

	always_ff @(posedge clk)
	begin
		if (commit)
		begin
			tbl_addr[cmt_ptr] <= commit_addr_i;
			tbl_len[cmt_ptr] <= commit_len_i;
		end
	end

	// each update needs its own flag value, so two never hit one entry
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `CW_OUTSTANDING; i++)
				tbl_flag[i] <= ST_FREE;
			cmt_ptr <= '0;
			prep_ptr <= '0;
			disp_ptr <= '0;
		end
		else
		begin
			if (commit)
			begin
				tbl_flag[cmt_ptr] <= ST_LAUNCHED;
				cmt_ptr <= cmt_ptr + 1'b1;
			end
			if (prepared)
			begin
				tbl_flag[prep_ptr] <= ST_READY;
				prep_ptr <= prep_ptr + 1'b1;
			end
			if (dispatched)
			begin
				tbl_flag[disp_ptr] <= ST_FREE;
				disp_ptr <= disp_ptr + 1'b1;
			end
		end
	end

endmodule

//--- source/aw_burst_splitter.sv
`timescale 1ns/1ps
`include "cw_defs.svh"

module aw_burst_splitter import cw_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       req_start_i,
	input  addr_t      start_addr_i,
	input  beat_cnt_t  beat_cnt_i,
	input  logic       commit_ok_i, // table slot free
	input  logic       bvalid_i,
	output logic       req_split_done_o,
	output logic       commit_valid_o,
	output addr_t      commit_addr_o,
	output burst_len_t commit_len_o,
	output logic       wt_req_fns_o
);

	localparam burst_len_t MAX_LEN = burst_len_t'(`CW_MAX_BURST - 1);
	localparam logic [2:0] OUT_MAX = 3'(`CW_OUTSTANDING);

	aw_state_e state;
	logic active; // request still being cut
	addr_t aw_addr; // next burst, beat aligned
	logic [8:0] page_left; // beats to the 4 KB edge, minus one
	beat_cnt_t req_left; // beats left in request, minus one
	burst_len_t min_res; // shared min unit result
	logic last_burst;
	logic commit;
	logic [2:0] out_cnt; // bursts waiting for B
	logic lb_fifo [`CW_OUTSTANDING]; // last-burst flag per outstanding burst
	tbl_ptr_t lb_wptr;
	tbl_ptr_t lb_rptr;

	assign commit_valid_o = (state == AW_COMMIT);
	assign commit_addr_o = aw_addr;
	assign commit_len_o = min_res;
	assign commit = commit_valid_o & commit_ok_i;
	assign req_split_done_o = commit & last_burst;
	assign wt_req_fns_o = bvalid_i & lb_fifo[lb_rptr];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= AW_WAIT;
		else
		begin
			case (state)
				AW_WAIT:
					if (active & (out_cnt != OUT_MAX))
						state <= AW_LEN;
				AW_LEN:
					state <= AW_COMMIT;
				AW_COMMIT:
					if (commit_ok_i)
						state <= AW_WAIT; // held while table is full
				default:
					state <= AW_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			active <= 1'b0;
		else if (req_start_i)
			active <= 1'b1;
		else if (req_split_done_o)
			active <= 1'b0;
	end

	// address and remaining counts
	always_ff @(posedge clk)
	begin
		if (req_start_i)
		begin
			aw_addr <= {start_addr_i[`CW_ADDR_W-1:3], 3'b000};
			page_left <= ~start_addr_i[11:3]; // 511 - beat index in page
			req_left <= beat_cnt_i;
		end
		else if (commit)
		begin
			aw_addr <= {aw_addr[`CW_ADDR_W-1:3] + (`CW_ADDR_W-3)'(min_res) + 1'b1, 3'b000};
			page_left <= page_left - {1'b0, min_res} - 9'd1;
			req_left <= req_left - min_res - 8'd1;
		end
	end

	// first cycle page vs max burst, second cycle against the request
	always_ff @(posedge clk)
	begin
		if (state == AW_WAIT)
			min_res <= (page_left <= {1'b0, MAX_LEN}) ? page_left[7:0] : MAX_LEN;
		else if (state == AW_LEN)
		begin
			min_res <= (req_left <= min_res) ? req_left : min_res;
			last_burst <= (req_left <= min_res);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_cnt <= 3'd0;
		else if (commit ^ bvalid_i)
			out_cnt <= bvalid_i ? out_cnt - 3'd1 : out_cnt + 3'd1;
	end

	always_ff @(posedge clk)
	begin
		if (commit)
			lb_fifo[lb_wptr] <= last_burst;
	end

	// B returns in commit order
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lb_wptr <= '0;
			lb_rptr <= '0;
		end
		else
		begin
			if (commit)
				lb_wptr <= lb_wptr + 1'b1;
			if (bvalid_i)
				lb_rptr <= lb_rptr + 1'b1;
		end
	end

endmodule

//--- source/wt_req_intake.sv
`timescale 1ns/1ps
`include "cw_defs.svh"

module wt_req_intake import cw_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  addr_t     wt_req_addr_i,
	input  btt_t      wt_req_btt_i,
	input  logic      wt_req_valid_i,
	output logic      wt_req_ready_o,
	input  logic      req_split_done_i, // last burst committed
	input  logic      msg_pop_i, // last feature taken by the packer
	output logic      req_start_o,
	output addr_t     start_addr_o,
	output beat_cnt_t beat_cnt_o,
	output keep_id_t  first_kid_o,
	output keep_id_t  last_kid_o,
	output logic      msg_valid_o
);

	localparam logic [1:0] MSG_DEPTH = 2'(`CW_REQ_MSG_DEPTH);

	logic busy; // splitter owns a request
	logic accept;
	logic [`CW_BTT_W:0] term_addr; // end offset from the beat-aligned base
	logic [`CW_BTT_W-3:0] beats_m1;
	keep_id_t last_kid_in;
	logic [5:0] msg_mem [`CW_REQ_MSG_DEPTH]; // {first_kid, last_kid}
	logic [5:0] msg_head;
	logic [1:0] msg_wptr;
	logic [1:0] msg_rptr;
	logic [1:0] msg_cnt;

	assign wt_req_ready_o = ~busy & (msg_cnt != MSG_DEPTH);
	assign accept = wt_req_valid_i & wt_req_ready_o;
	assign req_start_o = accept;
	assign start_addr_o = wt_req_addr_i;

	// low address bits count toward the first beat
	assign term_addr = {1'b0, wt_req_btt_i} + {{(`CW_BTT_W-2){1'b0}}, wt_req_addr_i[2:0]};
	// ceil(term / 8) - 1
	assign beats_m1 = term_addr[`CW_BTT_W:3] - {{(`CW_BTT_W-3){1'b0}}, ~|term_addr[2:0]};
	assign beat_cnt_o = beats_m1[7:0];
	assign last_kid_in = term_addr[2:0] - 3'd1; // 0 wraps to 7, full last beat

	// empty queue passes the new message straight through
	assign msg_head = (msg_cnt == 2'd0) ? {wt_req_addr_i[2:0], last_kid_in} : msg_mem[msg_rptr];
	assign msg_valid_o = (msg_cnt != 2'd0) | accept;
	assign first_kid_o = msg_head[5:3];
	assign last_kid_o = msg_head[2:0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (req_split_done_i)
			busy <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			msg_mem[msg_wptr] <= {wt_req_addr_i[2:0], last_kid_in};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			msg_wptr <= 2'd0;
			msg_rptr <= 2'd0;
			msg_cnt <= 2'd0;
		end
		else
		begin
			if (accept)
				msg_wptr <= (msg_wptr == MSG_DEPTH - 2'd1) ? 2'd0 : msg_wptr + 2'd1;
			if (msg_pop_i)
				msg_rptr <= (msg_rptr == MSG_DEPTH - 2'd1) ? 2'd0 : msg_rptr + 2'd1;
			msg_cnt <= msg_cnt + {1'b0, accept} - {1'b0, msg_pop_i};
		end
	end

endmodule

//--- source/cw_pkg.sv
`include "cw_defs.svh"

package cw_pkg;

	typedef logic [`CW_ADDR_W-1:0] addr_t; // byte address
	typedef logic [`CW_BTT_W-1:0] btt_t; // bytes to transfer
	typedef logic [7:0] beat_cnt_t; // beats in a request, minus one
	typedef logic [7:0] burst_len_t; // axi awlen encoding

	// byte lane inside a 64-bit beat
	typedef logic [2:0] keep_id_t;

	typedef logic [`CW_FEAT_W-1:0] feat_t;
	typedef logic [`CW_FEAT_W*`CW_FEATS_PER_BEAT-1:0] wdata_t;
	typedef logic [`CW_FEAT_W*`CW_FEATS_PER_BEAT/8-1:0] wstrb_t; // one bit per byte

	typedef logic [$clog2(`CW_OUTSTANDING)-1:0] tbl_ptr_t;

	// address split fsm
	typedef enum logic [1:0] {
		AW_WAIT, // outstanding room
		AW_LEN, // clip to request
		AW_COMMIT // hand to burst table
	} aw_state_e;

endpackage

//--- source/cw_defs.svh
`ifndef CW_DEFS_SVH
`define CW_DEFS_SVH

// axi address bus
`define CW_ADDR_W 32

// byte count of one write request, 2048 bytes max
`define CW_BTT_W 12

// feature and beat geometry
`define CW_FEAT_W 16
`define CW_FEATS_PER_BEAT 4 // four features fill a 64-bit beat

// burst limits
`define CW_MAX_BURST 32 // incr beats per burst
`define CW_OUTSTANDING 4 // bursts in flight, also burst table entries

// buffering
`define CW_REQ_MSG_DEPTH 3 // keep index messages
`define CW_WBUF_DEPTH 16 // W beats, power of two

`endif
